//--- tb/alu_golden.txt
// columns: opcode a b carry_in result flags op_err, all hex
// flags bits: 0 c, 1 z, 2 n, 3 o, 4 gt, 5 lt, 6 eq; a line with opcode ff ends the list
09 10 20 0 30 20 0
09 7f 01 0 80 1c 0
09 ff 01 0 00 13 0
0d 10 20 1 31 20 0
0a 05 07 0 fe 25 0
0a 80 01 0 7f 18 0
0b 05 07 0 02 20 0
0e 10 05 1 0a 10 0
0f 05 05 1 ff 45 0
05 ff 00 0 00 13 0
05 7f 7f 0 80 4c 0
08 00 00 0 ff 45 0
07 80 00 0 7f 18 0
03 80 00 0 80 1c 0
04 00 05 0 fb 24 0
01 3c 3c 0 3c 40 0
02 01 82 0 82 24 0
00 12 34 0 00 22 0
19 f0 3c 0 30 18 0
1a 0f f0 0 ff 2c 0
1b aa aa 0 00 4a 0
1c 00 ff 0 ff 2c 0
1d 80 7f 0 80 14 0
14 81 00 0 81 14 0
14 81 01 0 02 19 0
14 03 07 0 80 2d 0
15 03 01 0 01 11 0
15 80 09 0 00 1a 0
16 80 07 0 ff 14 0
16 40 0a 0 00 12 0
17 81 01 0 02 19 0
18 01 01 1 80 4d 0
17 55 09 1 55 11 0
18 00 02 1 40 20 0
10 03 04 0 00 00 1
12 08 02 0 00 00 1
1e 09 01 0 00 00 1
0c 05 03 0 00 00 1
ff 00 00 0 00 00 0

//--- tb.f
verilog/alu_pkg.sv
verilog/alu_operand_capture.sv
verilog/alu_adder_unit.sv
verilog/alu_logic_shift_unit.sv
verilog/alu_result_stage.sv
verilog/alu_top.sv
tb/alu_checker.sv
tb/tb_alu_top.sv

//--- Makefile
# Verilator build and run for the ALU testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= tb_alu_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_alu_top.sv
`timescale 1ns/1ps
/*
 * testbench for the handshake ALU, one four-phase transaction per golden vector
 * vectors come from tb/alu_golden.txt, so the run must start in the project root
 * comparing is done by alu_checker, this module drives and decides the verdict
 */
module tb_alu_top;
    import alu_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int FIELDS = 7;

    logic              clk;
    logic              rst_n;
    logic              req;
    alu_op_e           op;
    alu_word_t         a;
    alu_word_t         b;
    logic              carry_in;
    logic              ack;
    alu_word_t         result;
    logic [FLAG_W-1:0] flags;
    logic              op_err;

    logic [7:0] vec_mem [0:MAX_VEC*FIELDS-1];
    int         num_vec;
    logic       loaded;
    integer     seed;
    int         value_errors;
    int         protocol_errors;
    int         checked_count;

    alu_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .op       (op),
        .a        (a),
        .b        (b),
        .carry_in (carry_in),
        .ack      (ack),
        .result   (result),
        .flags    (flags),
        .op_err   (op_err)
    );

    alu_checker checker_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .ack             (ack),
        .result          (result),
        .flags           (flags),
        .op_err          (op_err),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .checked_count   (checked_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sits at the clock edge until ack shows the wanted level
    task automatic wait_for_ack(input logic level);
        do begin
            @(posedge clk);
        end while (ack !== level);
    endtask

    // operands go out one edge before req so they are stable when req is seen
    task automatic run_vector(input int idx);
        @(posedge clk);
        op <= alu_op_e'(vec_mem[idx*FIELDS][OP_W-1:0]);
        a <= vec_mem[idx*FIELDS+1];
        b <= vec_mem[idx*FIELDS+2];
        carry_in <= vec_mem[idx*FIELDS+3][0];
        @(posedge clk);
        req <= 1'b1;
        wait_for_ack(1'b1);
        @(posedge clk);
        req <= 1'b0;
        wait_for_ack(1'b0);
    endtask

    initial begin
        int gap;
        rst_n <= 1'b0;
        req <= 1'b0;
        op <= op_zero;
        a <= '0;
        b <= '0;
        carry_in <= 1'b0;
        seed = 65861;
        loaded = 1'b0;
        for (int i = 0; i < MAX_VEC*FIELDS; i++) begin
            vec_mem[i] = 8'hff;
        end
        $readmemh("tb/alu_golden.txt", vec_mem);
        // an opcode byte of ff ends the vector list
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec*FIELDS] != 8'hff) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            $display("no vectors were read from tb/alu_golden.txt");
        end
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int v = 0; v < num_vec; v++) begin
            run_vector(v);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("errors: %0d value, %0d protocol, %0d of %0d results checked",
                 value_errors, protocol_errors, checked_count, num_vec);
        if (num_vec > 0 && value_errors == 0 && protocol_errors == 0 &&
            checked_count == num_vec) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // each transaction takes nine edges plus an idle gap of up to three
    initial begin
        wait (loaded);
        repeat (num_vec * 12 + 50 + 8) @(posedge clk);
        $display("timeout: the handshake did not finish within the expected time");
        $display("Test failed");
        $finish;
    end

endmodule

//--- tb/alu_checker.sv
`timescale 1ns/1ps
/*
 * watches the ALU ports and compares every result against tb/alu_golden.txt
 * all values are sampled at the rising edge, before the DUT updates them
 * vectors are expected in file order, one per rising edge of ack
 */
module alu_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  logic                       ack,
    input  alu_pkg::alu_word_t         result,
    input  logic [alu_pkg::FLAG_W-1:0] flags,
    input  logic                       op_err,
    output int                         value_errors,
    output int                         protocol_errors,
    output int                         checked_count
);
    import alu_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int FIELDS = 7;

    logic [7:0]        exp_mem [0:MAX_VEC*FIELDS-1];
    string             flag_names [FLAG_W] = '{"c", "z", "n", "o", "gt", "lt", "eq"};
    logic              prev_req;
    logic              prev_ack;
    logic              prev_rst_n;
    logic              waiting;
    int                since_req;
    alu_word_t         held_result;
    logic [FLAG_W-1:0] held_flags;
    logic              held_err;

    initial begin
        value_errors = 0;
        protocol_errors = 0;
        checked_count = 0;
        prev_rst_n = 1'b0;
        for (int i = 0; i < MAX_VEC*FIELDS; i++) begin
            exp_mem[i] = 8'hff;
        end
        $readmemh("tb/alu_golden.txt", exp_mem);
    end

    task automatic check_field(input int idx, input string name,
                               input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch %s in vector %0d: got 0x%h expected 0x%h", name, idx, got, exp);
            value_errors++;
        end
    endtask

    // result, each flag on its own, then op_err
    task automatic compare_vector(input int idx);
        logic [7:0] exp_flags;
        if (idx >= MAX_VEC || exp_mem[idx*FIELDS] == 8'hff) begin
            $display("ack raised for result %0d, but the golden file has no such vector", idx);
            protocol_errors++;
        end else begin
            exp_flags = exp_mem[idx*FIELDS+5];
            check_field(idx, "result", result, exp_mem[idx*FIELDS+4]);
            for (int f = 0; f < FLAG_W; f++) begin
                check_field(idx, {"flag_", flag_names[f]}, 8'(flags[f]), 8'(exp_flags[f]));
            end
            check_field(idx, "op_err", 8'(op_err), exp_mem[idx*FIELDS+6]);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
            waiting = 1'b0;
            since_req = 0;
        end else begin
            if (!prev_rst_n && ack !== 1'b0) begin
                $display("ack is not low when reset is released");
                protocol_errors++;
            end
            // start counting edges when an idle DUT first sees req
            if (req && !prev_req && !ack) begin
                waiting = 1'b1;
                since_req = 0;
            end else if (waiting) begin
                since_req++;
            end
            if (ack && !prev_ack) begin
                // ack set at the second edge after req shows up at the third sample
                if (!waiting || since_req != 3) begin
                    $display("ack rose %0d edges after req instead of 2", since_req - 1);
                    protocol_errors++;
                end
                waiting = 1'b0;
                compare_vector(checked_count);
                checked_count++;
                held_result = result;
                held_flags = flags;
                held_err = op_err;
            end else if (ack && prev_ack) begin
                if (result !== held_result || flags !== held_flags || op_err !== held_err) begin
                    $display("outputs changed while ack was still high");
                    protocol_errors++;
                end
            end
            if (prev_ack && !prev_req && ack) begin
                $display("ack stayed high one edge after req was seen low");
                protocol_errors++;
            end
            prev_req = req;
            prev_ack = ack;
        end
        prev_rst_n = rst_n;
    end

endmodule

//--- verilog/alu_top.sv
`timescale 1ns/1ps
/*
 * 8-bit ALU behind a four-phase req/ack handshake
 * ack rises two edges after req is first sampled high, flags are active high
 * codes for multiply, divide, modulo, BCD and signed-magnitude subtract set op_err
 */
module alu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  alu_pkg::alu_op_e           op,
    input  alu_pkg::alu_word_t         a,
    input  alu_pkg::alu_word_t         b,
    input  logic                       carry_in,
    output logic                       ack,
    output alu_pkg::alu_word_t         result,
    output logic [alu_pkg::FLAG_W-1:0] flags,
    output logic                       op_err
);
    import alu_pkg::*;

    alu_op_e    cap_op;
    alu_word_t  cap_a;
    alu_word_t  cap_b;
    logic       cap_carry;
    adder_ctl_t adder_left;
    logic       adder_invert_right;
    logic       adder_carry_term;
    unit_sel_e  unit_sel;
    logic       start;

    alu_word_t  add_result;
    logic       add_carry;
    logic       add_overflow;
    alu_word_t  ls_result;
    logic       ls_carry;
    logic       ls_overflow;

    // handshake front end and opcode decode
    alu_operand_capture capture_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .ack                (ack),
        .op                 (op),
        .a                  (a),
        .b                  (b),
        .carry_in           (carry_in),
        .cap_op             (cap_op),
        .cap_a              (cap_a),
        .cap_b              (cap_b),
        .cap_carry          (cap_carry),
        .adder_left         (adder_left),
        .adder_invert_right (adder_invert_right),
        .adder_carry_term   (adder_carry_term),
        .unit_sel           (unit_sel),
        .start              (start)
    );

    alu_adder_unit adder_i (
        .cap_a              (cap_a),
        .cap_b              (cap_b),
        .cap_op             (cap_op),
        .adder_left         (adder_left),
        .adder_invert_right (adder_invert_right),
        .adder_carry_term   (adder_carry_term),
        .add_result         (add_result),
        .add_carry          (add_carry),
        .add_overflow       (add_overflow)
    );

    alu_logic_shift_unit logic_shift_i (
        .cap_a       (cap_a),
        .cap_b       (cap_b),
        .cap_op      (cap_op),
        .cap_carry   (cap_carry),
        .ls_result   (ls_result),
        .ls_carry    (ls_carry),
        .ls_overflow (ls_overflow)
    );

    // both units run every time, the result stage keeps the one that unit_sel names
    alu_result_stage result_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .start        (start),
        .unit_sel     (unit_sel),
        .cap_a        (cap_a),
        .cap_b        (cap_b),
        .add_result   (add_result),
        .add_carry    (add_carry),
        .add_overflow (add_overflow),
        .ls_result    (ls_result),
        .ls_carry     (ls_carry),
        .ls_overflow  (ls_overflow),
        .result       (result),
        .flags        (flags),
        .op_err       (op_err),
        .ack          (ack)
    );

endmodule

//--- verilog/alu_result_stage.sv
`timescale 1ns/1ps
/*
 * output side, registers the selected unit result and the flags on start and raises ack
 * outputs hold steady while ack is high, ack drops one edge after req is seen low
 * the compare flags are unsigned and come from the operands, not from the result
 */
module alu_result_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  logic                       start,
    input  alu_pkg::unit_sel_e         unit_sel,
    input  alu_pkg::alu_word_t         cap_a,
    input  alu_pkg::alu_word_t         cap_b,
    input  alu_pkg::alu_word_t         add_result,
    input  logic                       add_carry,
    input  logic                       add_overflow,
    input  alu_pkg::alu_word_t         ls_result,
    input  logic                       ls_carry,
    input  logic                       ls_overflow,
    output alu_pkg::alu_word_t         result,
    output logic [alu_pkg::FLAG_W-1:0] flags,
    output logic                       op_err,
    output logic                       ack
);
    import alu_pkg::*;

    alu_word_t         sel_result;
    logic              sel_carry;
    logic              sel_overflow;
    logic [FLAG_W-1:0] next_flags;

    // a rejected opcode leaves the zero defaults in place
    always_comb begin
        sel_result = '0;
        sel_carry = 1'b0;
        sel_overflow = 1'b0;
        case (unit_sel)
            unit_adder: begin
                sel_result = add_result;
                sel_carry = add_carry;
                sel_overflow = add_overflow;
            end
            unit_logic_shift: begin
                sel_result = ls_result;
                sel_carry = ls_carry;
                sel_overflow = ls_overflow;
            end
            default: sel_result = '0;
        endcase
    end

    always_comb begin
        next_flags = '0;
        if (unit_sel != unit_none) begin
            next_flags[FLAG_C] = sel_carry;
            next_flags[FLAG_Z] = (sel_result == '0);
            next_flags[FLAG_N] = sel_result[WORD_W-1];
            next_flags[FLAG_O] = sel_overflow;
            next_flags[FLAG_GT] = (cap_a > cap_b);
            next_flags[FLAG_LT] = (cap_a < cap_b);
            next_flags[FLAG_EQ] = (cap_a == cap_b);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
            flags <= '0;
            op_err <= 1'b0;
            ack <= 1'b0;
        end else if (start) begin
            result <= sel_result;
            flags <= next_flags;
            op_err <= (unit_sel == unit_none);
            ack <= 1'b1;
        end else if (!req) begin
            // requester has seen ack and let go, so close the handshake
            ack <= 1'b0;
        end
    end

endmodule

//--- verilog/alu_logic_shift_unit.sv
`timescale 1ns/1ps
/*
 * combinational bitwise, shift and rotate-through-carry unit
 * the shift count is the full value of b, shifts of nine or more clear the word
 * rotates act on the nine bits {carry_in, a}, so a count of nine is a full turn
 */
module alu_logic_shift_unit (
    input  alu_pkg::alu_word_t cap_a,
    input  alu_pkg::alu_word_t cap_b,
    input  alu_pkg::alu_op_e   cap_op,
    input  logic               cap_carry,
    output alu_pkg::alu_word_t ls_result,
    output logic               ls_carry,
    output logic               ls_overflow
);
    import alu_pkg::*;

    logic [WORD_W:0]        lsl_v;
    logic [WORD_W:0]        lsr_v;
    logic signed [WORD_W:0] asr_v;
    logic [WORD_W:0]        rot_in;
    logic [2*WORD_W+1:0]    rcl_v;
    logic [2*WORD_W+1:0]    rcr_v;
    logic [3:0]             rot_amt;

    // left shift keeps the last bit out in the ninth position
    assign lsl_v = {1'b0, cap_a} << cap_b;

    // right shifts keep the last bit out below bit zero
    assign lsr_v = {cap_a, 1'b0} >> cap_b;
    assign asr_v = $signed({cap_a, 1'b0}) >>> cap_b;

    // rotating a doubled copy turns the wrap into a plain shift
    assign rot_in = {cap_carry, cap_a};
    assign rot_amt = 4'(cap_b % 8'd9);
    assign rcl_v = {rot_in, rot_in} << rot_amt;
    assign rcr_v = {rot_in, rot_in} >> rot_amt;

    always_comb begin
        ls_result = '0;
        ls_carry = 1'b0;
        case (cap_op)
            op_and:   ls_result = cap_a & cap_b;
            op_or:    ls_result = cap_a | cap_b;
            op_xor:   ls_result = cap_a ^ cap_b;
            op_not_a: ls_result = ~cap_a;
            op_not_b: ls_result = ~cap_b;
            op_lsl: begin
                ls_result = lsl_v[WORD_W-1:0];
                ls_carry = lsl_v[WORD_W];
            end
            op_lsr: begin
                ls_result = lsr_v[WORD_W:1];
                ls_carry = lsr_v[0];
            end
            op_asr: begin
                ls_result = asr_v[WORD_W:1];
                ls_carry = asr_v[0];
            end
            // the upper copy after a left shift holds the rotated value
            op_rcl: {ls_carry, ls_result} = rcl_v[2*WORD_W+1:WORD_W+1];
            // the lower copy after a right shift holds the rotated value
            op_rcr: {ls_carry, ls_result} = rcr_v[WORD_W:0];
            default: begin
                ls_result = '0;
                ls_carry = 1'b0;
            end
        endcase
    end

    // for these operations overflow only reports a change of the top bit against a
    assign ls_overflow = ls_result[WORD_W-1] ^ cap_a[WORD_W-1];

endmodule

//--- verilog/alu_adder_unit.sv
`timescale 1ns/1ps
/*
 * combinational 9-bit adder/subtractor on the captured operands
 * the carry out of a subtraction is the borrow, negate always reports carry zero
 */
module alu_adder_unit (
    input  alu_pkg::alu_word_t  cap_a,
    input  alu_pkg::alu_word_t  cap_b,
    input  alu_pkg::alu_op_e    cap_op,
    input  alu_pkg::adder_ctl_t adder_left,
    input  logic                adder_invert_right,
    input  logic                adder_carry_term,
    output alu_pkg::alu_word_t  add_result,
    output logic                add_carry,
    output logic                add_overflow
);
    import alu_pkg::*;

    alu_word_t     left;
    alu_word_t     right;
    alu_word_t     right_eff;
    logic [WORD_W:0] sum;
    logic          is_negate;
    logic          add_ov;
    logic          sub_ov;

    always_comb begin
        case (adder_left)
            adder_left_a: left = cap_a;
            adder_left_b: left = cap_b;
            default:      left = '0;
        endcase
    end

    // the right operand is the value being subtracted or added
    // for B-A the roles swap, and decrement subtracts a constant one
    always_comb begin
        case (cap_op)
            op_neg_a, op_sub_ba, op_sub_ba_c:                  right = cap_a;
            op_neg_b, op_add, op_sub_ab, op_add_c, op_sub_ab_c: right = cap_b;
            op_dec_a, op_dec_b:                                right = WORD_W'(1);
            default:                                           right = '0;
        endcase
    end

    assign right_eff = adder_invert_right ? ~right : right;
    assign sum = {1'b0, left} + {1'b0, right_eff} + (WORD_W + 1)'(adder_carry_term);
    assign add_result = sum[WORD_W-1:0];

    // zero minus the operand is the only case with a zero left side and an inverted right
    assign is_negate = (adder_left == adder_left_zero) && adder_invert_right;

    // a raw carry out of a plus ~b plus one means no borrow, so flip it for subtraction
    assign add_carry = is_negate ? 1'b0 : (sum[WORD_W] ^ adder_invert_right);

    // same signs in, other sign out
    assign add_ov = ~(left[WORD_W-1] ^ right[WORD_W-1]) &
                    (left[WORD_W-1] ^ add_result[WORD_W-1]);

    // differing signs in, result sign not that of the left operand
    assign sub_ov = (left[WORD_W-1] ^ right[WORD_W-1]) &
                    (left[WORD_W-1] ^ add_result[WORD_W-1]);

    // only 0x80 cannot be negated in eight bits
    always_comb begin
        if (is_negate)
            add_overflow = (right == {1'b1, {(WORD_W-1){1'b0}}});
        else if (adder_invert_right)
            add_overflow = sub_ov;
        else
            add_overflow = add_ov;
    end

endmodule

//--- verilog/alu_operand_capture.sv
`timescale 1ns/1ps
/*
 * input side of the four-phase req/ack handshake, one operation in flight at a time
 * inputs must be stable while req is high, they are sampled on the edge that sees req
 * a new req is taken only after req and ack have both been low for a cycle
 */
module alu_operand_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  logic                ack,
    input  alu_pkg::alu_op_e    op,
    input  alu_pkg::alu_word_t  a,
    input  alu_pkg::alu_word_t  b,
    input  logic                carry_in,
    output alu_pkg::alu_op_e    cap_op,
    output alu_pkg::alu_word_t  cap_a,
    output alu_pkg::alu_word_t  cap_b,
    output logic                cap_carry,
    output alu_pkg::adder_ctl_t adder_left,
    output logic                adder_invert_right,
    output logic                adder_carry_term,
    output alu_pkg::unit_sel_e  unit_sel,
    output logic                start
);
    import alu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_fire,
        st_busy
    } cap_state_e;

    cap_state_e state;

    // decode of the captured opcode, loaded into the output registers in st_decode
    adder_ctl_t dec_left;
    logic       dec_invert;
    logic       dec_carry;
    unit_sel_e  dec_unit;

    // idle, then decode, then one cycle of start, then wait for the handshake to close
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (req) state <= st_decode;
                st_decode: state <= st_fire;
                st_fire:   state <= st_busy;
                st_busy:   if (!req && !ack) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            cap_op <= op;
            cap_a <= a;
            cap_b <= b;
            cap_carry <= carry_in;
        end
    end

    // subtraction is a plus ~right plus one, so a borrow in turns the carry term into ~carry
    always_comb begin
        dec_left = adder_left_a;
        dec_invert = 1'b0;
        dec_carry = 1'b0;
        dec_unit = unit_adder;
        case (cap_op)
            op_zero:     dec_left = adder_left_zero;
            op_pass_a:   dec_left = adder_left_a;
            op_pass_b:   dec_left = adder_left_b;
            op_neg_a, op_neg_b: begin
                dec_left = adder_left_zero;
                dec_invert = 1'b1;
                dec_carry = 1'b1;
            end
            op_inc_a:    dec_carry = 1'b1;
            op_inc_b: begin
                dec_left = adder_left_b;
                dec_carry = 1'b1;
            end
            op_dec_a, op_sub_ab: begin
                dec_invert = 1'b1;
                dec_carry = 1'b1;
            end
            op_dec_b, op_sub_ba: begin
                dec_left = adder_left_b;
                dec_invert = 1'b1;
                dec_carry = 1'b1;
            end
            op_add:      dec_left = adder_left_a;
            op_add_c:    dec_carry = cap_carry;
            op_sub_ab_c: begin
                dec_invert = 1'b1;
                dec_carry = ~cap_carry;
            end
            op_sub_ba_c: begin
                dec_left = adder_left_b;
                dec_invert = 1'b1;
                dec_carry = ~cap_carry;
            end
            op_lsl, op_lsr, op_asr, op_rcl, op_rcr,
            op_and, op_or, op_xor, op_not_a, op_not_b: dec_unit = unit_logic_shift;
            default:     dec_unit = unit_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            adder_left <= dec_left;
            adder_invert_right <= dec_invert;
            adder_carry_term <= dec_carry;
            unit_sel <= dec_unit;
        end
    end

    assign start = (state == st_fire);

endmodule

//--- verilog/alu_pkg.sv
/*
 * shared widths, opcode encoding and flag bit positions for the 8-bit ALU
 * opcode values keep the original 5-bit numbering, including the codes that are rejected
 * flags are active high, so a set bit means the condition holds
 */
package alu_pkg;

    // operand and result width
    localparam int WORD_W = 8;
    localparam int OP_W = 5;
    localparam int FLAG_W = 7;

    // bit positions inside the flags vector
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_O = 3;
    localparam int FLAG_GT = 4;
    localparam int FLAG_LT = 5;
    localparam int FLAG_EQ = 6;

    typedef logic [WORD_W-1:0] alu_word_t;

    // every code is listed so that the rejected ones can still be named
    typedef enum logic [OP_W-1:0] {
        op_zero        = 5'd0,
        op_pass_a      = 5'd1,
        op_pass_b      = 5'd2,
        op_neg_a       = 5'd3,
        op_neg_b       = 5'd4,
        op_inc_a       = 5'd5,
        op_inc_b       = 5'd6,
        op_dec_a       = 5'd7,
        op_dec_b       = 5'd8,
        op_add         = 5'd9,
        op_sub_ab      = 5'd10,
        op_sub_ba      = 5'd11,
        op_sub_signmag = 5'd12,
        op_add_c       = 5'd13,
        op_sub_ab_c    = 5'd14,
        op_sub_ba_c    = 5'd15,
        op_mul_lo      = 5'd16,
        op_mul_hi      = 5'd17,
        op_div         = 5'd18,
        op_mod         = 5'd19,
        op_lsl         = 5'd20,
        op_lsr         = 5'd21,
        op_asr         = 5'd22,
        op_rcl         = 5'd23,
        op_rcr         = 5'd24,
        op_and         = 5'd25,
        op_or          = 5'd26,
        op_xor         = 5'd27,
        op_not_a       = 5'd28,
        op_not_b       = 5'd29,
        op_bcd_add     = 5'd30,
        op_bcd_sub     = 5'd31
    } alu_op_e;

    // left operand of the adder, the right one is picked inside the adder from the opcode
    typedef enum logic [1:0] {
        adder_left_a,
        adder_left_b,
        adder_left_zero
    } adder_ctl_t;

    // which compute unit supplies the result, none marks a rejected opcode
    typedef enum logic [1:0] {
        unit_adder,
        unit_logic_shift,
        unit_none
    } unit_sel_e;

endpackage
